// ==== src/adc_pkg.sv ====
// ADC framing constants; SCLK_HALF must be at least 2 and all four converters share one frame.
`default_nettype none

package adc_pkg;

    // One converter result and the index that picks it.
    typedef logic [9:0] sample_t;
    typedef logic [1:0] channel_t;

    localparam int CHANNELS = 4;

    // clk cycles per sclk half period.
    localparam int SCLK_HALF = 4;

    localparam int FRAME_BITS = 16;  // sclk periods with cs low.
    localparam int LEAD_BITS = 3;    // Ignored bits ahead of the MSB.

    // Gap between frames, in sclk periods.
    localparam int CS_IDLE = 4;

endpackage

`default_nettype wire

// ==== src/link_pkg.sv ====
// UART link constants; BIT_CYCLES must be even, and only four command bytes are recognized.
`default_nettype none

package link_pkg;

    typedef logic [7:0] byte_t;

    // clk cycles per bit on both rxd and txd.
    localparam int BIT_CYCLES = 16;

    // ASCII '0'; '0' to '3' ask for channels 0 to 3.
    localparam byte_t CMD_BASE = 8'h30;

    // Reply sequencer, one send and one wait state per byte.
    typedef enum logic [2:0] {
        idle,
        send_high,
        wait_high,
        send_low,
        wait_low
    } reply_state_t;

endpackage

`default_nettype wire

// ==== src/adc_spi_sampler.sv ====
// Free-running after reset with no enable; miso is taken as already synchronous to clk.
`timescale 1ns/1ps
`default_nettype none

module adc_spi_sampler (
    input  wire                          clk,
    input  wire                          reset_b,
    input  wire [adc_pkg::CHANNELS-1:0]  miso,
    output logic                         cs,
    output logic                         sclk,
    output logic                         sample_valid,
    output adc_pkg::sample_t             sample_0,
    output adc_pkg::sample_t             sample_1,
    output adc_pkg::sample_t             sample_2,
    output adc_pkg::sample_t             sample_3
);
    import adc_pkg::*;

    localparam int HALF_W = $clog2(SCLK_HALF);
    localparam int BIT_W = $clog2(FRAME_BITS + 2 * CS_IDLE);
    localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(SCLK_HALF - 1);
    localparam logic [BIT_W-1:0] FRAME_END = BIT_W'(FRAME_BITS);
    localparam logic [BIT_W-1:0] IDLE_LAST = BIT_W'(2 * CS_IDLE - 1);
    localparam logic [BIT_W-1:0] FIRST_BIT = BIT_W'(LEAD_BITS);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(LEAD_BITS + $bits(sample_t) - 1);

    logic [HALF_W-1:0] half_cnt;
    logic [BIT_W-1:0]  bit_cnt;   // Frame bits, or half periods of the gap.
    logic              rise;
    sample_t           shift_q [CHANNELS];

    // Edge on which sclk goes high.
    assign rise = !cs && !sclk && half_cnt == HALF_LAST && bit_cnt != FRAME_END;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            cs <= 1'b1;
            sclk <= 1'b0;
            half_cnt <= '0;
            bit_cnt <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;
            if (cs) begin
                if (half_cnt == HALF_LAST) begin
                    half_cnt <= '0;
                    if (bit_cnt == IDLE_LAST) begin
                        cs <= 1'b0;       // Next frame.
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end else begin
                    half_cnt <= half_cnt + 1'b1;
                end
            end else if (bit_cnt == FRAME_END) begin
                cs <= 1'b1;               // One clk after the last fall.
                sample_valid <= 1'b1;
                bit_cnt <= '0;
            end else if (half_cnt == HALF_LAST) begin
                half_cnt <= '0;
                sclk <= !sclk;
                if (sclk) begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    // All four lines shift on the same edges, MSB first.
    always_ff @(posedge clk) begin
        if (rise && bit_cnt >= FIRST_BIT && bit_cnt <= LAST_BIT) begin
            for (int i = 0; i < CHANNELS; i++) begin
                shift_q[i] <= {shift_q[i][$bits(sample_t)-2:0], miso[i]};
            end
        end
    end

    assign sample_0 = shift_q[0];
    assign sample_1 = shift_q[1];
    assign sample_2 = shift_q[2];
    assign sample_3 = shift_q[3];

    a_sclk_low_idle: assert property (@(posedge clk) disable iff (!reset_b)
        cs |-> !sclk);

    // Samples are only offered as the frame closes.
    a_valid_at_cs_rise: assert property (@(posedge clk) disable iff (!reset_b)
        sample_valid |-> $rose(cs));

endmodule

`default_nettype wire

// ==== src/uart_rx.sv ====
// 8N1 only with no parity; a low stop bit or a glitch shorter than half a bit drops the byte.
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire              clk,
    input  wire              reset_b,
    input  wire              rxd,
    output logic             rx_valid,
    output link_pkg::byte_t  rx_byte
);
    import link_pkg::*;

    typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

    localparam int CNT_W = $clog2(BIT_CYCLES);
    localparam logic [CNT_W-1:0] MID = CNT_W'(BIT_CYCLES / 2 - 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(BIT_CYCLES - 1);

    rx_state_t        state;
    logic [2:0]       sync_q;   // Bit 1 is synchronized, bit 2 its previous value.
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            sync_q <= 3'b111;
            state <= rx_idle;
            cnt <= '0;
            bit_idx <= '0;
            rx_valid <= 1'b0;
        end else begin
            sync_q <= {sync_q[1:0], rxd};
            rx_valid <= 1'b0;
            case (state)
                rx_idle: begin
                    if (sync_q[2] && !sync_q[1]) begin
                        state <= rx_start;
                        cnt <= '0;
                    end
                end
                rx_start: begin
                    if (cnt == MID) begin
                        cnt <= '0;
                        bit_idx <= '0;
                        state <= sync_q[1] ? rx_idle : rx_data;  // Still low at mid-bit?
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                rx_data: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == LAST) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= rx_stop;
                        end
                    end
                end
                default: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == LAST) begin
                        state <= rx_idle;
                        rx_valid <= sync_q[1];  // Framing check.
                    end
                end
            endcase
        end
    end

    // LSB arrives first.
    always_ff @(posedge clk) begin
        if (state == rx_data && cnt == LAST) begin
            rx_byte <= {sync_q[1], rx_byte[7:1]};
        end
    end

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
// 8N1 only; tx_byte is taken on tx_start and a start while busy is not allowed.
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire              clk,
    input  wire              reset_b,
    input  wire              tx_start,
    input  wire link_pkg::byte_t tx_byte,
    output logic             txd,
    output logic             tx_busy
);
    import link_pkg::*;

    localparam int CNT_W = $clog2(BIT_CYCLES);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(BIT_CYCLES - 1);

    logic [CNT_W-1:0] cnt;
    logic [3:0]       bit_idx;   // 0 start, 1 to 8 data, 9 stop.
    logic [8:0]       shift_q;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            txd <= 1'b1;
            tx_busy <= 1'b0;
            cnt <= '0;
            bit_idx <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                txd <= 1'b0;
                tx_busy <= 1'b1;
                cnt <= '0;
                bit_idx <= '0;
            end
        end else begin
            cnt <= cnt + 1'b1;
            if (cnt == LAST) begin
                if (bit_idx == 4'd9) begin
                    tx_busy <= 1'b0;   // Stop bit done.
                end else begin
                    txd <= shift_q[0];
                    bit_idx <= bit_idx + 1'b1;
                end
            end
        end
    end

    // Stop bit rides in as the top bit.
    always_ff @(posedge clk) begin
        if (tx_start && !tx_busy) begin
            shift_q <= {1'b1, tx_byte};
        end else if (tx_busy && cnt == LAST) begin
            shift_q <= {1'b1, shift_q[8:1]};
        end
    end

    a_start_when_free: assert property (@(posedge clk) disable iff (!reset_b)
        tx_start |-> !tx_busy);

endmodule

`default_nettype wire

// ==== src/report_datapath.sv ====
// hold must come while rx_byte still holds the command; the two reply bytes read the held values.
`timescale 1ns/1ps
`default_nettype none

module report_datapath (
    input  wire                   clk,
    input  wire                   reset_b,
    input  wire                   sample_valid,
    input  wire adc_pkg::sample_t sample_0,
    input  wire adc_pkg::sample_t sample_1,
    input  wire adc_pkg::sample_t sample_2,
    input  wire adc_pkg::sample_t sample_3,
    input  wire                   hold,
    input  wire                   byte_sel,
    input  wire link_pkg::byte_t  rx_byte,
    output link_pkg::byte_t       tx_byte
);
    import adc_pkg::*;
    import link_pkg::*;

    sample_t  samples_q [CHANNELS];
    sample_t  hold_sample_q;
    sample_t  cur_sample;
    channel_t hold_ch_q;
    channel_t req_ch;
    channel_t cur_ch;
    byte_t    offset;

    assign offset = rx_byte - CMD_BASE;
    assign req_ch = channel_t'(offset);

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            for (int i = 0; i < CHANNELS; i++) begin
                samples_q[i] <= '0;
            end
        end else if (sample_valid) begin
            samples_q[0] <= sample_0;
            samples_q[1] <= sample_1;
            samples_q[2] <= sample_2;
            samples_q[3] <= sample_3;
        end
    end

    always_ff @(posedge clk) begin
        if (hold) begin
            hold_ch_q <= req_ch;
            hold_sample_q <= samples_q[req_ch];
        end
    end

    // Bypass so the first byte is right in the hold cycle.
    assign cur_ch = hold ? req_ch : hold_ch_q;
    assign cur_sample = hold ? samples_q[req_ch] : hold_sample_q;

    assign tx_byte = byte_sel ? cur_sample[7:0] : {cur_ch, 4'b0000, cur_sample[9:8]};

endmodule

`default_nettype wire

// ==== src/report_controller.sv ====
// One reply at a time; commands arriving before the second byte has gone out are dropped.
`timescale 1ns/1ps
`default_nettype none

module report_controller (
    input  wire                  clk,
    input  wire                  reset_b,
    input  wire                  rx_valid,
    input  wire link_pkg::byte_t rx_byte,
    input  wire                  tx_busy,
    output logic                 hold,
    output logic                 byte_sel,
    output logic                 tx_start
);
    import adc_pkg::*;
    import link_pkg::*;

    reply_state_t state;
    reply_state_t state_next;
    byte_t        offset;
    logic         is_cmd;

    // Bytes below CMD_BASE wrap to large offsets.
    assign offset = rx_byte - CMD_BASE;
    assign is_cmd = rx_valid && offset < byte_t'(CHANNELS);

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (is_cmd) begin
                    state_next = send_high;
                end
            end
            send_high: state_next = wait_high;
            wait_high: begin
                if (!tx_busy) begin
                    state_next = send_low;
                end
            end
            send_low: state_next = wait_low;
            default: begin
                if (!tx_busy) begin
                    state_next = idle;  // Stop bit of the low byte done.
                end
            end
        endcase
    end

    assign hold = (state == send_high);
    assign tx_start = (state == send_high) || (state == send_low);
    assign byte_sel = (state == send_low) || (state == wait_low);

    a_start_only_free: assert property (@(posedge clk) disable iff (!reset_b)
        tx_start |-> !tx_busy);

endmodule

`default_nettype wire

// ==== src/adc_uart_top.sv ====
// Single clock design; reset_b is used as given, with no debounce or synchronizer.
`timescale 1ns/1ps
`default_nettype none

module adc_uart_top (
    input  wire                         clk,
    input  wire                         reset_b,
    input  wire [adc_pkg::CHANNELS-1:0] miso,
    input  wire                         rxd,
    output logic                        cs,
    output logic                        sclk,
    output logic                        txd
);
    import adc_pkg::*;
    import link_pkg::*;

    logic    sample_valid;
    sample_t sample_0;
    sample_t sample_1;
    sample_t sample_2;
    sample_t sample_3;
    logic    rx_valid;
    byte_t   rx_byte;
    byte_t   tx_byte;
    logic    hold;
    logic    byte_sel;
    logic    tx_start;
    logic    tx_busy;

    adc_spi_sampler u_sampler (
        .clk(clk),
        .reset_b(reset_b),
        .miso(miso),
        .cs(cs),
        .sclk(sclk),
        .sample_valid(sample_valid),
        .sample_0(sample_0),
        .sample_1(sample_1),
        .sample_2(sample_2),
        .sample_3(sample_3)
    );

    report_datapath u_datapath (
        .clk(clk),
        .reset_b(reset_b),
        .sample_valid(sample_valid),
        .sample_0(sample_0),
        .sample_1(sample_1),
        .sample_2(sample_2),
        .sample_3(sample_3),
        .hold(hold),
        .byte_sel(byte_sel),
        .rx_byte(rx_byte),
        .tx_byte(tx_byte)
    );

    report_controller u_controller (
        .clk(clk),
        .reset_b(reset_b),
        .rx_valid(rx_valid),
        .rx_byte(rx_byte),
        .tx_busy(tx_busy),
        .hold(hold),
        .byte_sel(byte_sel),
        .tx_start(tx_start)
    );

    uart_rx u_uart_rx (
        .clk(clk),
        .reset_b(reset_b),
        .rxd(rxd),
        .rx_valid(rx_valid),
        .rx_byte(rx_byte)
    );

    uart_tx u_uart_tx (
        .clk(clk),
        .reset_b(reset_b),
        .tx_start(tx_start),
        .tx_byte(tx_byte),
        .txd(txd),
        .tx_busy(tx_busy)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
// Free-running 8 ns clock; reset_b stays low for 16 cycles and is released on a falling edge.
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset_b
);
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        reset_b = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_b = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tests/tb_adc_uart_top.sv ====
// Inputs change and outputs are sampled on falling clk; ADC values only change while cs is high.
`timescale 1ns/1ps
`default_nettype none

module tb_adc_uart_top;
    import adc_pkg::*;
    import link_pkg::*;

    localparam int FRAME_CYCLES = (FRAME_BITS + CS_IDLE) * 2 * SCLK_HALF + 2;
    localparam int BYTE_CYCLES = 10 * BIT_CYCLES;
    localparam int QUIET_CYCLES = 4 * BYTE_CYCLES;  // Two full replies.

    logic                clk;
    logic                reset_b;
    logic [CHANNELS-1:0] miso;
    logic                rxd;
    logic                cs;
    logic                sclk;
    logic                txd;

    sample_t adc_value [CHANNELS];
    byte_t   rx_bytes [$];   // Bytes decoded from txd.
    int      frame_count;
    int      seed;

    tb_clock u_clock (
        .clk(clk),
        .reset_b(reset_b)
    );

    adc_uart_top i_dut (
        .clk(clk),
        .reset_b(reset_b),
        .miso(miso),
        .rxd(rxd),
        .cs(cs),
        .sclk(sclk),
        .txd(txd)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int got, input int expected);
        assert (got == expected) else begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s is %0h, expected %0h",
                $time, name, got, expected));
        end
    endtask

    // Lead and trailing bits are zero.
    function automatic logic frame_bit(input sample_t value, input int pos);
        if (pos >= LEAD_BITS && pos < LEAD_BITS + $bits(sample_t)) begin
            return value[$bits(sample_t) - 1 - (pos - LEAD_BITS)];
        end
        return 1'b0;
    endfunction

    function automatic byte_t high_byte(input int channel, input sample_t value);
        return {channel[1:0], 4'b0000, value[9:8]};
    endfunction

    // ADC models; all four share one bit position.
    initial begin
        int   pos;
        logic last_cs;
        logic last_sclk;
        miso = '0;
        pos = 0;
        last_cs = 1'b1;
        last_sclk = 1'b0;
        forever begin
            @(negedge clk);
            if (!cs && last_cs) begin
                pos = 0;
            end else if (!sclk && last_sclk) begin
                pos = pos + 1;   // Next bit after each falling sclk.
            end
            for (int i = 0; i < CHANNELS; i++) begin
                miso[i] = cs ? 1'b0 : frame_bit(adc_value[i], pos);
            end
            last_cs = cs;
            last_sclk = sclk;
        end
    end

    // Frame monitor.
    initial begin
        int   rises;
        logic last_cs;
        logic last_sclk;
        rises = 0;
        last_cs = 1'b1;
        last_sclk = 1'b0;
        frame_count = 0;
        forever begin
            @(negedge clk);
            if (reset_b) begin
                if (cs) begin
                    check_value("sclk while cs high", int'(sclk), 0);
                end
                if (!cs && sclk && !last_sclk) begin
                    rises++;
                end
                if (cs && !last_cs) begin
                    check_value("sclk rises per frame", rises, FRAME_BITS);
                    rises = 0;
                    frame_count++;
                end
            end
            last_cs = cs;
            last_sclk = sclk;
        end
    end

    // UART host receiver on txd, mid-bit sampling.
    initial begin
        byte_t value;
        forever begin
            @(negedge clk);
            if (reset_b && !txd) begin
                repeat (BIT_CYCLES / 2) @(negedge clk);
                assert (!txd) else abort_run("Start bit on txd ended before mid-bit");
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CYCLES) @(negedge clk);
                    value[i] = txd;
                end
                repeat (BIT_CYCLES) @(negedge clk);
                check_value("txd stop bit", int'(txd), 1);
                rx_bytes.push_back(value);
            end
        end
    end

    // 8N1 frame on rxd, LSB first.
    task automatic send_byte(input byte_t value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rxd = frame[i];
            repeat (BIT_CYCLES) @(negedge clk);
        end
    endtask

    task automatic wait_frames(input int count);
        int target;
        target = frame_count + count;
        for (int t = 0; frame_count < target; t++) begin
            if (t > count * FRAME_CYCLES) begin
                abort_run("Timed out waiting for ADC frames to complete");
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_bytes(input int count);
        for (int t = 0; rx_bytes.size() < count; t++) begin
            if (t > 3 * BYTE_CYCLES) begin
                abort_run("Timed out waiting for reply bytes on txd");
            end
            @(negedge clk);
        end
    endtask

    task automatic expect_quiet(input int count);
        for (int t = 0; t < QUIET_CYCLES; t++) begin
            @(negedge clk);
            check_value("bytes received on txd", rx_bytes.size(), count);
        end
    endtask

    task automatic load_adc_values();
        sample_t value;
        for (int t = 0; !cs; t++) begin
            if (t > FRAME_CYCLES) begin
                abort_run("Timed out waiting for cs to go high");
            end
            @(negedge clk);
        end
        for (int i = 0; i < CHANNELS; i++) begin
            value = sample_t'($random(seed));
            if (value == adc_value[i]) begin
                value = ~value;
            end
            adc_value[i] = value;
        end
    endtask

    task automatic request_and_check(input int channel);
        int base;
        base = rx_bytes.size();
        send_byte(byte_t'(CMD_BASE + channel));
        wait_bytes(base + 2);
        check_value("txd reply high byte", int'(rx_bytes[base]),
            int'(high_byte(channel, adc_value[channel])));
        check_value("txd reply low byte", int'(rx_bytes[base + 1]),
            int'(adc_value[channel][7:0]));
    endtask

    initial begin
        int    base;
        byte_t junk;
        seed = 32'h258b;
        rxd = 1'b1;
        for (int i = 0; i < CHANNELS; i++) begin
            adc_value[i] = '0;
        end
        @(negedge clk);
        for (int t = 0; !reset_b; t++) begin
            if (t > 64) begin
                abort_run("reset_b was never released");
            end
            @(negedge clk);
        end
        check_value("cs", int'(cs), 1);
        check_value("sclk", int'(sclk), 0);
        check_value("txd", int'(txd), 1);

        load_adc_values();
        wait_frames(2);
        check_value("bytes received on txd", rx_bytes.size(), 0);
        for (int ch = 0; ch < CHANNELS; ch++) begin
            request_and_check(ch);
        end

        // New values must show up after two frames.
        load_adc_values();
        wait_frames(2);
        for (int ch = 0; ch < CHANNELS; ch++) begin
            request_and_check(ch);
        end

        base = rx_bytes.size();
        send_byte(CMD_BASE - 8'd1);
        send_byte(CMD_BASE + 8'd4);
        send_byte(8'h00);
        send_byte(8'hff);
        for (int i = 0; i < 4; i++) begin
            junk = byte_t'($random(seed));
            if (junk >= CMD_BASE && junk < CMD_BASE + 8'd4) begin
                junk = junk ^ 8'h80;
            end
            send_byte(junk);
        end
        expect_quiet(base);

        // Second command lands while the first reply is on txd.
        base = rx_bytes.size();
        send_byte(CMD_BASE + 8'd1);
        for (int t = 0; txd; t++) begin
            if (t > BYTE_CYCLES) begin
                abort_run("Timed out waiting for a reply to start on txd");
            end
            @(negedge clk);
        end
        send_byte(CMD_BASE + 8'd2);
        wait_bytes(base + 2);
        expect_quiet(base + 2);
        check_value("txd reply high byte", int'(rx_bytes[base]),
            int'(high_byte(1, adc_value[1])));
        check_value("txd reply low byte", int'(rx_bytes[base + 1]), int'(adc_value[1][7:0]));

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
src/adc_pkg.sv
src/link_pkg.sv
src/adc_spi_sampler.sv
src/uart_rx.sv
src/uart_tx.sv
src/report_datapath.sv
src/report_controller.sv
src/adc_uart_top.sv
tests/tb_clock.sv
tests/tb_adc_uart_top.sv

// ==== Makefile ====
SIM     := verilator
FLAGS   := --binary --timing --assert
TOP     := tb_adc_uart_top
FLIST   := flist.f
OBJ_DIR := obj_dir

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(FLIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | awk '{ print } /^No errors$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
